/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = procTb
FILELIST = src.f
BUILDDIR = obj_dir
LOG      = sim.log
PASSMSG  = PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

run: compile
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASSMSG)" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

/* hw/decode.sv */
`timescale 1ns/1ps
`default_nettype none
module decode import procPkg::*; (
   input  logic                    clk,
   input  logic                    reset,
   input  instrT                   instrD,
   input  logic [dataWidth-1:0]    pcIncD,
   input  logic                    validD,
   input  logic                    flush,
   input  logic                    regWrtW,
   input  logic [regAddrWidth-1:0] wrtRegW,
   input  logic [dataWidth-1:0]    wbDataW,
   output logic                    stall,
   output logic                    haltSeen,
   output logic                    validX,
   output logic [4:0]              opX,
   output logic [1:0]              funcX,
   output logic [regAddrWidth-1:0] rsX,
   output logic [regAddrWidth-1:0] rtX,
   output logic [regAddrWidth-1:0] rdX,
   output logic                    regWrtX,
   output logic [1:0]              wbSelX,
   output logic                    memWrtX,
   output logic                    memRdX,
   output logic [dataWidth-1:0]    inAX,
   output logic [dataWidth-1:0]    inBX,
   output logic [dataWidth-1:0]    immX,
   output logic [dataWidth-1:0]    pcIncX
);

   logic [dataWidth-1:0]    regFile [1 << regAddrWidth];
   logic [4:0]              op;
   logic [regAddrWidth-1:0] srcA;
   logic [regAddrWidth-1:0] srcB;
   logic [regAddrWidth-1:0] dest;
   logic                    usesA;
   logic                    usesB;
   logic                    regWrt;
   logic                    memWrt;
   logic                    memRd;
   logic [1:0]              wbSel;
   logic [dataWidth-1:0]    imm;
   logic [dataWidth-1:0]    valA;
   logic [dataWidth-1:0]    valB;
   logic                    issue;
   logic                    haltFlag;

   assign op   = instrD.rFormat.opcode;
   assign srcA = instrD.rFormat.rs;
   // Store data register shares bits 7:5 with rt
   assign srcB = instrD.rFormat.rt;

   always_comb begin
      usesA  = 1'b0;
      usesB  = 1'b0;
      regWrt = 1'b0;
      memWrt = 1'b0;
      memRd  = 1'b0;
      wbSel  = wbAlu;
      dest   = instrD.iFormat.rd;
      imm    = {{(dataWidth-5){instrD.iFormat.imm[4]}}, instrD.iFormat.imm};
      case (op)
         opAlu: begin
            usesA  = 1'b1;
            usesB  = 1'b1;
            regWrt = 1'b1;
            dest   = instrD.rFormat.rd;
         end
         opAddi: begin
            usesA  = 1'b1;
            regWrt = 1'b1;
         end
         opLd: begin
            usesA  = 1'b1;
            regWrt = 1'b1;
            memRd  = 1'b1;
            wbSel  = wbMem;
         end
         opSt: begin
            usesA  = 1'b1;
            usesB  = 1'b1;
            memWrt = 1'b1;
         end
         opLbi: begin
            regWrt = 1'b1;
            wbSel  = wbImm;
            dest   = instrD.lFormat.rs;
            imm    = {{(dataWidth-8){instrD.lFormat.imm[7]}}, instrD.lFormat.imm};
         end
         opBeqz, opBnez: begin
            usesA = 1'b1;
            imm   = {{(dataWidth-8){instrD.lFormat.imm[7]}}, instrD.lFormat.imm};
         end
         opJ: begin
            imm = {{(dataWidth-11){instrD.jFormat.disp[10]}}, instrD.jFormat.disp};
         end
         default: begin
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (regWrtW) begin
         regFile[wrtRegW] <= wbDataW;
      end
   end

   // Same-cycle writeback reads the new value
   assign valA = (regWrtW && wrtRegW == srcA) ? wbDataW : regFile[srcA];
   assign valB = (regWrtW && wrtRegW == srcB) ? wbDataW : regFile[srcB];

   // Load in execute feeding a source here
   assign stall = validD && memRdX &&
                  ((usesA && srcA == rdX) || (usesB && srcB == rdX));
   assign issue    = validD && !stall && !flush;
   assign haltSeen = haltFlag || (validD && op == opHalt);

   always_ff @(posedge clk) begin
      if (reset) begin
         validX   <= 1'b0;
         regWrtX  <= 1'b0;
         memWrtX  <= 1'b0;
         memRdX   <= 1'b0;
         haltFlag <= 1'b0;
      end else begin
         validX  <= issue;
         regWrtX <= issue && regWrt;
         memWrtX <= issue && memWrt;
         memRdX  <= issue && memRd;
         if (validD && !flush && op == opHalt) begin
            haltFlag <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      opX    <= op;
      funcX  <= instrD.rFormat.func;
      rsX    <= srcA;
      rtX    <= srcB;
      rdX    <= dest;
      wbSelX <= wbSel;
      inAX   <= valA;
      inBX   <= valB;
      immX   <= imm;
      pcIncX <= pcIncD;
   end

   // A load in execute cannot also be a taken branch
   stallNotFlushed: assert property (
      @(posedge clk) disable iff (reset)
      !(stall && flush)
   ) else $error("decode: load-use stall and branch flush in the same cycle");

endmodule
`default_nettype wire

/* hw/execute.sv */
`timescale 1ns/1ps
`default_nettype none
module execute import procPkg::*; (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    validX,
   input  logic [4:0]              opX,
   input  logic [1:0]              funcX,
   input  logic [regAddrWidth-1:0] rsX,
   input  logic [regAddrWidth-1:0] rtX,
   input  logic [regAddrWidth-1:0] rdX,
   input  logic                    regWrtX,
   input  logic [1:0]              wbSelX,
   input  logic                    memWrtX,
   input  logic                    memRdX,
   input  logic [dataWidth-1:0]    inAX,
   input  logic [dataWidth-1:0]    inBX,
   input  logic [dataWidth-1:0]    immX,
   input  logic [dataWidth-1:0]    pcIncX,
   input  logic [dataWidth-1:0]    fwdDataM,
   input  logic                    regWrtW,
   input  logic [regAddrWidth-1:0] wrtRegW,
   input  logic [dataWidth-1:0]    wbDataW,
   output logic                    redirect,
   output logic [dataWidth-1:0]    redirectPc,
   output logic                    validM,
   output logic [dataWidth-1:0]    aluOutM,
   output logic [dataWidth-1:0]    storeDataM,
   output logic [dataWidth-1:0]    immM,
   output logic                    regWrtM,
   output logic [regAddrWidth-1:0] wrtRegM,
   output logic [1:0]              wbSelM,
   output logic                    memWrtM,
   output logic                    memRdM,
   output logic                    haltM
);

   logic [dataWidth-1:0] opA;
   logic [dataWidth-1:0] opB;
   logic [dataWidth-1:0] aluB;
   logic [dataWidth-1:0] aluOut;
   logic                 taken;

   // Memory stage is younger than writeback, so it is checked first
   always_comb begin
      if (regWrtM && wrtRegM == rsX && wbSelM != wbMem) begin
         opA = fwdDataM;
      end else if (regWrtW && wrtRegW == rsX) begin
         opA = wbDataW;
      end else begin
         opA = inAX;
      end
      if (regWrtM && wrtRegM == rtX && wbSelM != wbMem) begin
         opB = fwdDataM;
      end else if (regWrtW && wrtRegW == rtX) begin
         opB = wbDataW;
      end else begin
         opB = inBX;
      end
   end

   assign aluB = (opX == opAlu) ? opB : immX;

   always_comb begin
      aluOut = opA + aluB;
      if (opX == opAlu) begin
         case (funcX)
            funcSub: aluOut = opA - aluB;
            funcAnd: aluOut = opA & aluB;
            funcXor: aluOut = opA ^ aluB;
            default: aluOut = opA + aluB;
         endcase
      end
   end

   always_comb begin
      case (opX)
         opBeqz:  taken = (opA == '0);
         opBnez:  taken = (opA != '0);
         opJ:     taken = 1'b1;
         default: taken = 1'b0;
      endcase
   end

   assign redirect   = validX && taken;
   assign redirectPc = pcIncX + immX;

   always_ff @(posedge clk) begin
      if (reset) begin
         validM  <= 1'b0;
         regWrtM <= 1'b0;
         memWrtM <= 1'b0;
         memRdM  <= 1'b0;
         haltM   <= 1'b0;
      end else begin
         validM  <= validX;
         regWrtM <= regWrtX;
         memWrtM <= memWrtX;
         memRdM  <= memRdX;
         haltM   <= validX && opX == opHalt;
      end
   end

   always_ff @(posedge clk) begin
      aluOutM    <= aluOut;
      storeDataM <= opB;
      immM       <= immX;
      wrtRegM    <= rdX;
      wbSelM     <= wbSelX;
   end

   // A taken branch must also squash the decode slot behind it
   redirectFlushes: assert property (
      @(posedge clk) disable iff (reset)
      redirect |=> !validX
   ) else $error("execute: instruction issued behind a taken branch");

endmodule
`default_nettype wire

/* hw/fetch.sv */
`timescale 1ns/1ps
`default_nettype none
module fetch import procPkg::*; (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 stall,
   input  logic                 redirect,
   input  logic [dataWidth-1:0] redirectPc,
   input  logic                 haltSeen,
   output instrT                instrD,
   output logic [dataWidth-1:0] pcIncD,
   output logic                 validD
);

   logic [dataWidth-1:0] rom [romDepth];
   logic [dataWidth-1:0] pc;
   logic [dataWidth-1:0] pcInc;
   logic                 advance;

   initial begin
      $readmemh("sim/prog.hex", rom);
   end

   assign pcInc   = pc + 1'b1;
   assign advance = !redirect && !haltSeen && !stall;

   // Redirect wins over halt and stall
   always_ff @(posedge clk) begin
      if (reset) begin
         pc     <= '0;
         validD <= 1'b0;
      end else if (redirect) begin
         pc     <= redirectPc;
         validD <= 1'b0;
      end else if (haltSeen) begin
         validD <= 1'b0;
      end else if (!stall) begin
         pc     <= pcInc;
         validD <= 1'b1;
      end
   end

   // Fetch-to-decode payload, held while stalled
   always_ff @(posedge clk) begin
      if (advance) begin
         instrD <= rom[pc[romAddrWidth-1:0]];
         pcIncD <= pcInc;
      end
   end

   pcInRange: assert property (
      @(posedge clk) disable iff (reset)
      pc < dataWidth'(romDepth)
   ) else $error("fetch: pc 0x%h ran past the instruction ROM", pc);

endmodule
`default_nettype wire

/* hw/memory.sv */
`timescale 1ns/1ps
`default_nettype none
module memory import procPkg::*; (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    validM,
   input  logic [dataWidth-1:0]    aluOutM,
   input  logic [dataWidth-1:0]    storeDataM,
   input  logic [dataWidth-1:0]    immM,
   input  logic                    regWrtM,
   input  logic [regAddrWidth-1:0] wrtRegM,
   input  logic [1:0]              wbSelM,
   input  logic                    memWrtM,
   input  logic                    memRdM,
   input  logic                    haltM,
   output logic [dataWidth-1:0]    fwdDataM,
   output logic                    regWrtW,
   output logic [regAddrWidth-1:0] wrtRegW,
   output logic [dataWidth-1:0]    wbDataW,
   output logic                    halt
);

   logic [dataWidth-1:0]    ram [ramDepth];
   logic [ramAddrWidth-1:0] ramAddr;
   logic [dataWidth-1:0]    loadData;
   logic [dataWidth-1:0]    wbData;

   assign ramAddr  = aluOutM[ramAddrWidth-1:0];
   assign loadData = ram[ramAddr];

   always_ff @(posedge clk) begin
      if (validM && memWrtM) begin
         ram[ramAddr] <= storeDataM;
      end
   end

   // Load data is not ready in time for forwarding
   assign fwdDataM = (wbSelM == wbImm) ? immM : aluOutM;

   always_comb begin
      case (wbSelM)
         wbMem:   wbData = loadData;
         wbImm:   wbData = immM;
         default: wbData = aluOutM;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         regWrtW <= 1'b0;
         halt    <= 1'b0;
      end else begin
         regWrtW <= validM && regWrtM;
         if (validM && haltM) begin
            halt <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      wrtRegW <= wrtRegM;
      wbDataW <= wbData;
   end

   oneMemOp: assert property (
      @(posedge clk) disable iff (reset)
      (memWrtM || memRdM) |-> validM && !(memWrtM && memRdM)
   ) else $error("memory: read and write requested together");

endmodule
`default_nettype wire

/* hw/proc.sv */
`timescale 1ns/1ps
`default_nettype none
module proc import procPkg::*; (
   input  logic                    clk,
   input  logic                    reset,
   output logic                    commitValid,
   output logic [regAddrWidth-1:0] commitReg,
   output logic [dataWidth-1:0]    commitData,
   output logic                    storeValid,
   output logic [dataWidth-1:0]    storeAddr,
   output logic [dataWidth-1:0]    storeData,
   output logic                    halt
);

   instrT                   instrD;
   logic [dataWidth-1:0]    pcIncD;
   logic                    validD;
   logic                    stall;
   logic                    haltSeen;
   logic                    redirect;
   logic [dataWidth-1:0]    redirectPc;
   logic                    validX;
   logic [4:0]              opX;
   logic [1:0]              funcX;
   logic [regAddrWidth-1:0] rsX;
   logic [regAddrWidth-1:0] rtX;
   logic [regAddrWidth-1:0] rdX;
   logic                    regWrtX;
   logic [1:0]              wbSelX;
   logic                    memWrtX;
   logic                    memRdX;
   logic [dataWidth-1:0]    inAX;
   logic [dataWidth-1:0]    inBX;
   logic [dataWidth-1:0]    immX;
   logic [dataWidth-1:0]    pcIncX;
   logic                    validM;
   logic [dataWidth-1:0]    aluOutM;
   logic [dataWidth-1:0]    storeDataM;
   logic [dataWidth-1:0]    immM;
   logic                    regWrtM;
   logic [regAddrWidth-1:0] wrtRegM;
   logic [1:0]              wbSelM;
   logic                    memWrtM;
   logic                    memRdM;
   logic                    haltM;
   logic [dataWidth-1:0]    fwdDataM;
   logic                    regWrtW;
   logic [regAddrWidth-1:0] wrtRegW;
   logic [dataWidth-1:0]    wbDataW;

   fetch fetchStage (.clk(clk), .reset(reset), .stall(stall), .redirect(redirect),
      .redirectPc(redirectPc), .haltSeen(haltSeen), .instrD(instrD), .pcIncD(pcIncD),
      .validD(validD));

   decode decodeStage (.clk(clk), .reset(reset), .instrD(instrD), .pcIncD(pcIncD),
      .validD(validD), .flush(redirect), .regWrtW(regWrtW), .wrtRegW(wrtRegW),
      .wbDataW(wbDataW), .stall(stall), .haltSeen(haltSeen), .validX(validX), .opX(opX),
      .funcX(funcX), .rsX(rsX), .rtX(rtX), .rdX(rdX), .regWrtX(regWrtX), .wbSelX(wbSelX),
      .memWrtX(memWrtX), .memRdX(memRdX), .inAX(inAX), .inBX(inBX), .immX(immX),
      .pcIncX(pcIncX));

   execute executeStage (.clk(clk), .reset(reset), .validX(validX), .opX(opX),
      .funcX(funcX), .rsX(rsX), .rtX(rtX), .rdX(rdX), .regWrtX(regWrtX), .wbSelX(wbSelX),
      .memWrtX(memWrtX), .memRdX(memRdX), .inAX(inAX), .inBX(inBX), .immX(immX),
      .pcIncX(pcIncX), .fwdDataM(fwdDataM), .regWrtW(regWrtW), .wrtRegW(wrtRegW),
      .wbDataW(wbDataW), .redirect(redirect), .redirectPc(redirectPc), .validM(validM),
      .aluOutM(aluOutM), .storeDataM(storeDataM), .immM(immM), .regWrtM(regWrtM),
      .wrtRegM(wrtRegM), .wbSelM(wbSelM), .memWrtM(memWrtM), .memRdM(memRdM),
      .haltM(haltM));

   memory memoryStage (.clk(clk), .reset(reset), .validM(validM), .aluOutM(aluOutM),
      .storeDataM(storeDataM), .immM(immM), .regWrtM(regWrtM), .wrtRegM(wrtRegM),
      .wbSelM(wbSelM), .memWrtM(memWrtM), .memRdM(memRdM), .haltM(haltM),
      .fwdDataM(fwdDataM), .regWrtW(regWrtW), .wrtRegW(wrtRegW), .wbDataW(wbDataW),
      .halt(halt));

   // Retirement trace
   assign commitValid = regWrtW;
   assign commitReg   = wrtRegW;
   assign commitData  = wbDataW;
   assign storeValid  = memWrtM;
   assign storeAddr   = aluOutM;
   assign storeData   = storeDataM;

endmodule
`default_nettype wire

/* hw/procPkg.sv */
package procPkg;

   localparam int dataWidth    = 16;
   localparam int regAddrWidth = 3;
   localparam int romDepth     = 256;
   localparam int ramDepth     = 256;
   localparam int romAddrWidth = $clog2(romDepth);
   localparam int ramAddrWidth = $clog2(ramDepth);

   // Opcodes, top five bits of every instruction
   localparam logic [4:0] opHalt = 5'b00000;
   localparam logic [4:0] opNop  = 5'b00001;
   localparam logic [4:0] opJ    = 5'b00100;
   localparam logic [4:0] opAddi = 5'b01000;
   localparam logic [4:0] opBeqz = 5'b01100;
   localparam logic [4:0] opBnez = 5'b01101;
   localparam logic [4:0] opSt   = 5'b10000;
   localparam logic [4:0] opLd   = 5'b10001;
   localparam logic [4:0] opLbi  = 5'b11000;
   localparam logic [4:0] opAlu  = 5'b11011;

   // R-format function field, sub is rs minus rt
   localparam logic [1:0] funcAdd = 2'b00;
   localparam logic [1:0] funcSub = 2'b01;
   localparam logic [1:0] funcAnd = 2'b10;
   localparam logic [1:0] funcXor = 2'b11;

   // Writeback data select
   localparam logic [1:0] wbAlu = 2'b00;
   localparam logic [1:0] wbMem = 2'b01;
   localparam logic [1:0] wbImm = 2'b10;

   typedef union packed {
      struct packed {
         logic [4:0] opcode;
         logic [2:0] rs;
         logic [2:0] rt;
         logic [2:0] rd;
         logic [1:0] func;
      } rFormat;
      struct packed {
         logic [4:0]        opcode;
         logic [2:0]        rs;
         logic [2:0]        rd;
         logic signed [4:0] imm;
      } iFormat;
      struct packed {
         logic [4:0]        opcode;
         logic [2:0]        rs;
         logic signed [7:0] imm;
      } lFormat;
      struct packed {
         logic [4:0]         opcode;
         logic signed [10:0] disp;
      } jFormat;
   } instrT;

endpackage

/* sim/clkGen.sv */
`timescale 1ns/1ps
module clkGen (
   output logic clk
);

   // 100 ns period
   localparam int halfPeriod = 50;

   initial begin
      clk = 1'b0;
      forever begin
         #halfPeriod clk = ~clk;
      end
   end

endmodule

/* sim/procTb.sv */
`timescale 1ns/1ps
module procTb import procPkg::*; ();

   localparam int resetCycles = 16;
   localparam int haltTimeout = 500;
   localparam int quietCycles = 20;
   localparam int stepLimit   = 1000;
   localparam int evNone      = 0;
   localparam int evCommit    = 1;
   localparam int evStore     = 2;
   localparam int evEnd       = 3;

   logic                    clk;
   logic                    reset;
   logic                    commitValid;
   logic [regAddrWidth-1:0] commitReg;
   logic [dataWidth-1:0]    commitData;
   logic                    storeValid;
   logic [dataWidth-1:0]    storeAddr;
   logic [dataWidth-1:0]    storeData;
   logic                    halt;

   // Architectural model state
   logic [dataWidth-1:0]    prog [romDepth];
   logic [dataWidth-1:0]    modelReg [1 << regAddrWidth];
   logic [dataWidth-1:0]    modelMem [ramDepth];
   logic [dataWidth-1:0]    modelPc;

   // Expected trace, refreshed on the falling edge after each event
   logic                    commitExpected;
   logic [regAddrWidth-1:0] expReg;
   logic [dataWidth-1:0]    expCommitData;
   logic                    storeExpected;
   logic [dataWidth-1:0]    expStoreAddr;
   logic [dataWidth-1:0]    expStoreData;
   logic [dataWidth-1:0]    evWhere;
   logic [dataWidth-1:0]    evValue;
   int                      commitKind;
   int                      storeKind;
   int                      errorCount;
   int                      commitCount;
   int                      storeCount;

   clkGen clockSource (.clk(clk));

   proc i_proc (.clk(clk), .reset(reset), .commitValid(commitValid), .commitReg(commitReg),
      .commitData(commitData), .storeValid(storeValid), .storeAddr(storeAddr),
      .storeData(storeData), .halt(halt));

   task automatic loadModel();
      $readmemh("sim/prog.hex", prog);
      for (int i = 0; i < (1 << regAddrWidth); i++) begin
         modelReg[i] = '0;
      end
      for (int i = 0; i < ramDepth; i++) begin
         modelMem[i] = '0;
      end
      modelPc = '0;
   endtask

   // Runs the program until the next register write or store
   task automatic nextEvent(output int kind, output logic [dataWidth-1:0] where,
                            output logic [dataWidth-1:0] value);
      instrT                   w;
      logic [dataWidth-1:0]    a;
      logic [dataWidth-1:0]    b;
      logic [dataWidth-1:0]    imm5;
      logic [dataWidth-1:0]    imm8;
      logic [dataWidth-1:0]    addr;
      logic [dataWidth-1:0]    result;
      logic [dataWidth-1:0]    nextPc;
      logic [regAddrWidth-1:0] dest;
      int                      steps;
      kind   = evNone;
      where  = '0;
      value  = '0;
      result = '0;
      steps  = 0;
      while (kind == evNone) begin
         w      = prog[modelPc[romAddrWidth-1:0]];
         a      = modelReg[w.rFormat.rs];
         // Store data and the ALU rt share bits 7:5
         b      = modelReg[w.rFormat.rt];
         imm5   = {{(dataWidth-5){w.iFormat.imm[4]}}, w.iFormat.imm};
         imm8   = {{(dataWidth-8){w.lFormat.imm[7]}}, w.lFormat.imm};
         addr   = a + imm5;
         dest   = w.iFormat.rd;
         nextPc = modelPc + 1'b1;
         case (w.rFormat.opcode)
            opAlu: begin
               dest = w.rFormat.rd;
               case (w.rFormat.func)
                  funcAdd: result = a + b;
                  funcSub: result = a - b;
                  funcAnd: result = a & b;
                  default: result = a ^ b;
               endcase
               kind = evCommit;
            end
            opAddi: begin
               result = addr;
               kind   = evCommit;
            end
            opLbi: begin
               dest   = w.lFormat.rs;
               result = imm8;
               kind   = evCommit;
            end
            opLd: begin
               result = modelMem[addr[ramAddrWidth-1:0]];
               kind   = evCommit;
            end
            opSt: begin
               modelMem[addr[ramAddrWidth-1:0]] = b;
               where = addr;
               value = b;
               kind  = evStore;
            end
            opBeqz: begin
               if (a == '0) begin
                  nextPc = modelPc + 1'b1 + imm8;
               end
            end
            opBnez: begin
               if (a != '0) begin
                  nextPc = modelPc + 1'b1 + imm8;
               end
            end
            opJ: nextPc = modelPc + 1'b1 + {{(dataWidth-11){w.jFormat.disp[10]}}, w.jFormat.disp};
            opNop: begin
            end
            opHalt: begin
               // Parked on the halt so later calls land here again
               nextPc = modelPc;
               kind   = evEnd;
            end
            default: begin
               $display("ERROR: model found an unknown opcode at pc 0x%h", modelPc);
               errorCount++;
               kind = evEnd;
            end
         endcase
         if (kind == evCommit) begin
            modelReg[dest] = result;
            where = dataWidth'(dest);
            value = result;
         end
         modelPc = nextPc;
         steps++;
         if (kind == evNone && steps >= stepLimit) begin
            $display("ERROR: model ran %0d instructions without any commit or store", steps);
            errorCount++;
            kind = evEnd;
         end
      end
   endtask

   // Writeback is older than the store in memory, so it is matched first
   always @(negedge clk) begin
      if (commitValid) begin
         nextEvent(commitKind, evWhere, evValue);
         commitExpected = (commitKind == evCommit);
         expReg         = evWhere[regAddrWidth-1:0];
         expCommitData  = evValue;
         commitCount++;
      end
      if (storeValid) begin
         nextEvent(storeKind, evWhere, evValue);
         storeExpected = (storeKind == evStore);
         expStoreAddr  = evWhere;
         expStoreData  = evValue;
         storeCount++;
      end
   end

   quietInReset: assert property (
      @(posedge clk) $past(reset) |-> !commitValid && !storeValid && !halt
   ) else begin
      $display("ERROR: trace or halt active during or right after reset");
      errorCount++;
   end

   commitInOrder: assert property (
      @(posedge clk) disable iff (reset) commitValid |-> commitExpected
   ) else begin
      $display("ERROR: register commit where the model expected none");
      errorCount++;
   end

   commitRegOk: assert property (
      @(posedge clk) disable iff (reset) commitValid && commitExpected |-> commitReg == expReg
   ) else begin
      $display("FAILED commitReg: got 0x%h expected 0x%h", $sampled(commitReg), $sampled(expReg));
      errorCount++;
   end

   commitDataOk: assert property (
      @(posedge clk) disable iff (reset)
      commitValid && commitExpected |-> commitData == expCommitData
   ) else begin
      $display("FAILED commitData: got 0x%h expected 0x%h", $sampled(commitData),
               $sampled(expCommitData));
      errorCount++;
   end

   storeInOrder: assert property (
      @(posedge clk) disable iff (reset) storeValid |-> storeExpected
   ) else begin
      $display("ERROR: store where the model expected none");
      errorCount++;
   end

   storeAddrOk: assert property (
      @(posedge clk) disable iff (reset) storeValid && storeExpected |-> storeAddr == expStoreAddr
   ) else begin
      $display("FAILED storeAddr: got 0x%h expected 0x%h", $sampled(storeAddr),
               $sampled(expStoreAddr));
      errorCount++;
   end

   storeDataOk: assert property (
      @(posedge clk) disable iff (reset) storeValid && storeExpected |-> storeData == expStoreData
   ) else begin
      $display("FAILED storeData: got 0x%h expected 0x%h", $sampled(storeData),
               $sampled(expStoreData));
      errorCount++;
   end

   haltSticky: assert property (
      @(posedge clk) disable iff (reset) halt |=> halt
   ) else begin
      $display("ERROR: halt dropped before reset");
      errorCount++;
   end

   quietAfterHalt: assert property (
      @(posedge clk) disable iff (reset) halt |-> !commitValid && !storeValid
   ) else begin
      $display("ERROR: commit or store seen after halt");
      errorCount++;
   end

   task automatic holdReset();
      for (int i = 0; i < resetCycles; i++) begin
         @(negedge clk);
      end
      reset = 1'b0;
   endtask

   task automatic waitForHalt(output logic timedOut);
      int cycles;
      cycles = 0;
      while (!halt && cycles < haltTimeout) begin
         @(negedge clk);
         cycles++;
      end
      timedOut = !halt;
      if (timedOut) begin
         $display("ERROR: halt did not rise within %0d cycles", haltTimeout);
         errorCount++;
      end
   endtask

   task automatic idleAfterHalt();
      for (int i = 0; i < quietCycles; i++) begin
         @(negedge clk);
      end
   endtask

   task automatic checkModelDrained();
      int                   kind;
      logic [dataWidth-1:0] where;
      logic [dataWidth-1:0] value;
      nextEvent(kind, where, value);
      modelDrained: assert (kind == evEnd) else begin
         $display("ERROR: model still expects a commit or store that never retired");
         errorCount++;
      end
   endtask

   initial begin
      logic timedOut;
      reset          = 1'b1;
      errorCount     = 0;
      commitCount    = 0;
      storeCount     = 0;
      commitExpected = 1'b0;
      storeExpected  = 1'b0;
      expReg         = '0;
      expCommitData  = '0;
      expStoreAddr   = '0;
      expStoreData   = '0;
      loadModel();
      holdReset();
      waitForHalt(timedOut);
      if (!timedOut) begin
         idleAfterHalt();
         checkModelDrained();
      end
      $display("Summary: %0d commits, %0d stores, %0d errors", commitCount, storeCount,
               errorCount);
      if (errorCount == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

/* sim/prog.hex */
// One 16-bit instruction word per line, loaded from address 0
// Columns: hex word, then its assembly
C010 // lbi  r0, 16
C105 // lbi  r1, 5
C203 // lbi  r2, 3
D94C // add  r3, r1, r2
DB31 // sub  r4, r3, r1
DC77 // xor  r5, r4, r3
DD7A // and  r6, r5, r3
46FE // addi r7, r6, -2
80E1 // st   r7, 1(r0)
8841 // ld   r2, 1(r0)
DA2C // add  r3, r2, r1
6302 // beqz r3, +2
C403 // lbi  r4, 3
C500 // lbi  r5, 0
DD34 // add  r5, r5, r1
449F // addi r4, r4, -1
6CFD // bnez r4, -3
6401 // beqz r4, +1
C655 // lbi  r6, 0x55
2002 // j    +2
8022 // st   r1, 2(r0)
8023 // st   r1, 3(r0)
80A2 // st   r5, 2(r0)
88C2 // ld   r6, 2(r0)
0000 // halt

/* src.f */
hw/procPkg.sv
hw/fetch.sv
hw/decode.sv
hw/execute.sv
hw/memory.sv
hw/proc.sv
sim/clkGen.sv
sim/procTb.sv
